// ==== pcim_consts.svh ====
`ifndef PCIM_CONSTS_SVH
`define PCIM_CONSTS_SVH

// axi side
`define PCIM_ADDR_W 64
`define PCIM_DATA_W 32
`define PCIM_ID_W   4
`define PCIM_LEN_W  8

// error and mismatch counters, packed side by side in REG_ERRS
`define PCIM_CNT_W  16

// config bus
`define CFG_ADDR_W  8
`define CFG_DATA_W  32

// register map
`define REG_CTRL    8'h00  // bit0 write, bit1 read
`define REG_ADDR_LO 8'h04
`define REG_ADDR_HI 8'h08
`define REG_LEN     8'h0C  // beats minus one
`define REG_PATTERN 8'h10
`define REG_STATUS  8'h14  // busy, wr done, rd done
`define REG_ERRS    8'h18  // {mismatch, resp err}

`endif

// ==== pcim_pkg.sv ====
`include "pcim_consts.svh"

package pcim_pkg;

  // shared by aw and ar
  typedef struct packed {
    logic [`PCIM_ID_W-1:0]   id;
    logic [`PCIM_ADDR_W-1:0] addr;
    logic [`PCIM_LEN_W-1:0]  len;
  } aw_beat_t;

  typedef struct packed {
    logic [`PCIM_DATA_W-1:0]   data;
    logic [`PCIM_DATA_W/8-1:0] strb;  // always all ones
    logic                      last;
  } w_beat_t;

  typedef struct packed {
    logic [`PCIM_ID_W-1:0] id;
    logic [1:0]            resp;
  } b_beat_t;

  typedef struct packed {
    logic [`PCIM_ID_W-1:0]   id;
    logic [`PCIM_DATA_W-1:0] data;
    logic [1:0]              resp;
    logic                    last;
  } r_beat_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_ADDR,
    ST_WR_DATA,
    ST_WR_RESP,
    ST_RD_ADDR,
    ST_RD_DATA
  } tg_state_t;

endpackage

// ==== axi_if.sv ====
`include "pcim_consts.svh"

interface axi_if import pcim_pkg::*; ();
  aw_beat_t aw;
  logic     awvalid;
  logic     awready;
  w_beat_t  w;
  logic     wvalid;
  logic     wready;
  b_beat_t  b;
  logic     bvalid;
  logic     bready;
  aw_beat_t ar;
  logic     arvalid;
  logic     arready;
  r_beat_t  r;
  logic     rvalid;
  logic     rready;

  modport master (
    output aw, awvalid, w, wvalid, bready, ar, arvalid, rready,
    input  awready, wready, b, bvalid, arready, r, rvalid
  );

  modport slave (
    input  aw, awvalid, w, wvalid, bready, ar, arvalid, rready,
    output awready, wready, b, bvalid, arready, r, rvalid
  );
endinterface

// job setup one way, status and counters the other
interface tg_ctrl_if ();
  logic                    start_wr;
  logic                    start_rd;
  logic [`PCIM_ADDR_W-1:0] job_addr;
  logic [`PCIM_LEN_W-1:0]  job_len;
  logic [`PCIM_DATA_W-1:0] pattern;
  logic                    busy;
  logic                    wr_done;
  logic                    rd_done;
  logic [`PCIM_CNT_W-1:0]  resp_err_cnt;
  logic [`PCIM_CNT_W-1:0]  mismatch_cnt;

  modport regs (
    output start_wr, start_rd, job_addr, job_len, pattern,
    input  busy, wr_done, rd_done, resp_err_cnt, mismatch_cnt
  );

  modport gen (
    input  start_wr, start_rd, job_addr, job_len, pattern,
    output busy, wr_done, rd_done, resp_err_cnt, mismatch_cnt
  );
endinterface

// ==== cfg_regs.sv ====
`include "pcim_consts.svh"

module cfg_regs (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  logic [`CFG_ADDR_W-1:0] cfg_addr,
  input  logic [`CFG_DATA_W-1:0] cfg_wdata,
  input  logic                   cfg_wr,
  input  logic                   cfg_rd,
  output logic                   cfg_ack,
  output logic [`CFG_DATA_W-1:0] cfg_rdata,
  tg_ctrl_if.regs                ctrl
);

  logic                   req_pending;  // request acked, waiting for it to drop
  logic                   access;
  logic [`CFG_DATA_W-1:0] rd_mux;

  assign access = (cfg_wr || cfg_rd) && !req_pending;

  always_comb begin
    case (cfg_addr)
      `REG_ADDR_LO: rd_mux = ctrl.job_addr[31:0];
      `REG_ADDR_HI: rd_mux = ctrl.job_addr[`PCIM_ADDR_W-1:32];
      `REG_LEN:     rd_mux = `CFG_DATA_W'(ctrl.job_len);
      `REG_PATTERN: rd_mux = ctrl.pattern;
      `REG_STATUS:  rd_mux = `CFG_DATA_W'({ctrl.rd_done, ctrl.wr_done, ctrl.busy});
      `REG_ERRS:    rd_mux = {ctrl.mismatch_cnt, ctrl.resp_err_cnt};
      default:      rd_mux = '0;  // ctrl reads back zero too
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      req_pending   <= 1'b0;
      cfg_ack       <= 1'b0;
      ctrl.start_wr <= 1'b0;
      ctrl.start_rd <= 1'b0;
      ctrl.job_addr <= '0;
      ctrl.job_len  <= '0;
      ctrl.pattern  <= '0;
    end else begin
      cfg_ack       <= access;
      ctrl.start_wr <= 1'b0;
      ctrl.start_rd <= 1'b0;

      if (access) begin
        req_pending <= 1'b1;
      end else if (!cfg_wr && !cfg_rd) begin
        req_pending <= 1'b0;
      end

      if (access && cfg_wr) begin
        case (cfg_addr)
          `REG_CTRL: begin
            // pulse lines up with cfg_ack
            ctrl.start_wr <= cfg_wdata[0] && !ctrl.busy;
            ctrl.start_rd <= cfg_wdata[1] && !ctrl.busy;
          end
          `REG_ADDR_LO: ctrl.job_addr[31:0]               <= cfg_wdata;
          `REG_ADDR_HI: ctrl.job_addr[`PCIM_ADDR_W-1:32]  <= cfg_wdata;
          `REG_LEN:     ctrl.job_len                      <= cfg_wdata[`PCIM_LEN_W-1:0];
          `REG_PATTERN: ctrl.pattern                      <= cfg_wdata;
          default: ;  // status and errs are read only
        endcase
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (access && cfg_rd) begin
      cfg_rdata <= rd_mux;
    end
  end

endmodule

// ==== traffic_gen.sv ====
`include "pcim_consts.svh"

module traffic_gen import pcim_pkg::*; (
  input  logic  aclk,
  input  logic  rst_n,
  tg_ctrl_if.gen ctrl,
  axi_if.master  axi
);

  tg_state_t               state;
  logic                    do_rd;     // read follows the write
  logic [`PCIM_LEN_W-1:0]  beat_cnt;
  logic [`PCIM_LEN_W-1:0]  len_q;
  logic [`PCIM_ADDR_W-1:0] addr_q;
  logic [`PCIM_DATA_W-1:0] pattern_q;
  logic [`PCIM_ID_W-1:0]   wr_id;
  logic [`PCIM_ID_W-1:0]   rd_id;
  logic [`PCIM_DATA_W-1:0] exp_data;
  logic                    w_last;
  logic                    job_start;

  function automatic logic [`PCIM_CNT_W-1:0] sat_inc(input logic [`PCIM_CNT_W-1:0] v);
    return (&v) ? v : v + 1'b1;
  endfunction

  assign job_start = (state == ST_IDLE) && (ctrl.start_wr || ctrl.start_rd);

  // same value drives wdata and predicts rdata
  assign exp_data = pattern_q + `PCIM_DATA_W'(beat_cnt);
  assign w_last   = (beat_cnt == len_q);

  assign axi.awvalid = (state == ST_WR_ADDR);
  assign axi.aw      = '{id: wr_id, addr: addr_q, len: len_q};

  assign axi.wvalid  = (state == ST_WR_DATA);
  assign axi.w       = '{data: exp_data, strb: {(`PCIM_DATA_W/8){1'b1}}, last: w_last};

  assign axi.bready  = (state == ST_WR_RESP);

  assign axi.arvalid = (state == ST_RD_ADDR);
  assign axi.ar      = '{id: rd_id, addr: addr_q, len: len_q};

  assign axi.rready  = (state == ST_RD_DATA);

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state             <= ST_IDLE;
      do_rd             <= 1'b0;
      beat_cnt          <= '0;
      wr_id             <= '0;
      rd_id             <= '0;
      ctrl.busy         <= 1'b0;
      ctrl.wr_done      <= 1'b0;
      ctrl.rd_done      <= 1'b0;
      ctrl.resp_err_cnt <= '0;
      ctrl.mismatch_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (job_start) begin
            ctrl.busy         <= 1'b1;
            ctrl.wr_done      <= 1'b0;
            ctrl.rd_done      <= 1'b0;
            ctrl.resp_err_cnt <= '0;
            ctrl.mismatch_cnt <= '0;
            do_rd             <= ctrl.start_rd;
            state             <= ctrl.start_wr ? ST_WR_ADDR : ST_RD_ADDR;
          end
        end

        ST_WR_ADDR: begin
          if (axi.awready) begin
            beat_cnt <= '0;
            state    <= ST_WR_DATA;
          end
        end

        ST_WR_DATA: begin
          if (axi.wready) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (w_last) begin
              state <= ST_WR_RESP;
            end
          end
        end

        ST_WR_RESP: begin
          if (axi.bvalid) begin
            ctrl.wr_done <= 1'b1;
            wr_id        <= wr_id + 1'b1;
            if (axi.b.resp != 2'b00) begin
              ctrl.resp_err_cnt <= sat_inc(ctrl.resp_err_cnt);
            end
            if (do_rd) begin
              state <= ST_RD_ADDR;
            end else begin
              ctrl.busy <= 1'b0;
              state     <= ST_IDLE;
            end
          end
        end

        ST_RD_ADDR: begin
          if (axi.arready) begin
            beat_cnt <= '0;
            state    <= ST_RD_DATA;
          end
        end

        ST_RD_DATA: begin
          if (axi.rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (axi.r.data != exp_data) begin
              ctrl.mismatch_cnt <= sat_inc(ctrl.mismatch_cnt);
            end
            if (axi.r.resp != 2'b00) begin
              ctrl.resp_err_cnt <= sat_inc(ctrl.resp_err_cnt);
            end
            if (axi.r.last) begin
              ctrl.rd_done <= 1'b1;
              rd_id        <= rd_id + 1'b1;
              ctrl.busy    <= 1'b0;
              state        <= ST_IDLE;
            end
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  // job snapshot, cfg writes during a job do not disturb it
  always_ff @(posedge aclk) begin
    if (job_start) begin
      addr_q    <= ctrl.job_addr;
      len_q     <= ctrl.job_len;
      pattern_q <= ctrl.pattern;
    end
  end

endmodule

// ==== axi_chan_slice.sv ====
module axi_chan_slice import pcim_pkg::*; #(
  parameter type payload_t = aw_beat_t
) (
  input  logic     aclk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // main entry drives the output, skid catches the beat of a stalled cycle
  logic     skid_valid;
  payload_t skid_data;
  logic     main_load;

  assign in_ready  = !skid_valid;  // room while under two entries
  assign main_load = !out_valid || out_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        if (skid_valid) begin
          out_valid  <= 1'b1;
          skid_valid <= 1'b0;
        end else begin
          out_valid <= in_valid;
        end
      end else if (in_valid && in_ready) begin
        skid_valid <= 1'b1;  // output stalled, park it
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (in_ready) begin
      skid_data <= in_data;
    end
  end

endmodule

// ==== pcim_master.sv ====
`include "pcim_consts.svh"

module pcim_master import pcim_pkg::*; (
  input  logic                      aclk,
  input  logic                      rst_n,

  input  logic [`CFG_ADDR_W-1:0]    cfg_addr,
  input  logic [`CFG_DATA_W-1:0]    cfg_wdata,
  input  logic                      cfg_wr,
  input  logic                      cfg_rd,
  output logic                      cfg_ack,
  output logic [`CFG_DATA_W-1:0]    cfg_rdata,

  output logic [`PCIM_ID_W-1:0]     awid,
  output logic [`PCIM_ADDR_W-1:0]   awaddr,
  output logic [`PCIM_LEN_W-1:0]    awlen,
  output logic                      awvalid,
  input  logic                      awready,

  output logic [`PCIM_DATA_W-1:0]   wdata,
  output logic [`PCIM_DATA_W/8-1:0] wstrb,
  output logic                      wlast,
  output logic                      wvalid,
  input  logic                      wready,

  input  logic [`PCIM_ID_W-1:0]     bid,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  output logic                      bready,

  output logic [`PCIM_ID_W-1:0]     arid,
  output logic [`PCIM_ADDR_W-1:0]   araddr,
  output logic [`PCIM_LEN_W-1:0]    arlen,
  output logic                      arvalid,
  input  logic                      arready,

  input  logic [`PCIM_ID_W-1:0]     rid,
  input  logic [`PCIM_DATA_W-1:0]   rdata,
  input  logic [1:0]                rresp,
  input  logic                      rlast,
  input  logic                      rvalid,
  output logic                      rready
);

  tg_ctrl_if ctrl ();
  axi_if     gen_axi ();

  aw_beat_t aw_out;
  aw_beat_t ar_out;
  w_beat_t  w_out;
  b_beat_t  b_in;
  r_beat_t  r_in;

  // struct to pin unpacking
  assign awid   = aw_out.id;
  assign awaddr = aw_out.addr;
  assign awlen  = aw_out.len;
  assign wdata  = w_out.data;
  assign wstrb  = w_out.strb;
  assign wlast  = w_out.last;
  assign arid   = ar_out.id;
  assign araddr = ar_out.addr;
  assign arlen  = ar_out.len;
  assign b_in   = '{id: bid, resp: bresp};
  assign r_in   = '{id: rid, data: rdata, resp: rresp, last: rlast};

  cfg_regs cfg_regs_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .ctrl      (ctrl.regs)
  );

  traffic_gen traffic_gen_inst (
    .aclk  (aclk),
    .rst_n (rst_n),
    .ctrl  (ctrl.gen),
    .axi   (gen_axi.master)
  );

  // outward: aw, w, ar
  axi_chan_slice #(.payload_t(aw_beat_t)) aw_slice_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (gen_axi.awvalid),
    .in_ready  (gen_axi.awready),
    .in_data   (gen_axi.aw),
    .out_valid (awvalid),
    .out_ready (awready),
    .out_data  (aw_out)
  );

  axi_chan_slice #(.payload_t(w_beat_t)) w_slice_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (gen_axi.wvalid),
    .in_ready  (gen_axi.wready),
    .in_data   (gen_axi.w),
    .out_valid (wvalid),
    .out_ready (wready),
    .out_data  (w_out)
  );

  axi_chan_slice #(.payload_t(aw_beat_t)) ar_slice_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (gen_axi.arvalid),
    .in_ready  (gen_axi.arready),
    .in_data   (gen_axi.ar),
    .out_valid (arvalid),
    .out_ready (arready),
    .out_data  (ar_out)
  );

  // inward: b, r
  axi_chan_slice #(.payload_t(b_beat_t)) b_slice_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (bvalid),
    .in_ready  (bready),
    .in_data   (b_in),
    .out_valid (gen_axi.bvalid),
    .out_ready (gen_axi.bready),
    .out_data  (gen_axi.b)
  );

  axi_chan_slice #(.payload_t(r_beat_t)) r_slice_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (rvalid),
    .in_ready  (rready),
    .in_data   (r_in),
    .out_valid (gen_axi.rvalid),
    .out_ready (gen_axi.rready),
    .out_data  (gen_axi.r)
  );

endmodule

// ==== pcim_props.sv ====
`include "pcim_consts.svh"

module pcim_props (
  input logic                                      aclk,
  input logic                                      rst_n,
  input logic                                      awvalid,
  input logic                                      awready,
  input logic [`PCIM_ID_W+`PCIM_ADDR_W+`PCIM_LEN_W-1:0] aw_bits,
  input logic                                      wvalid,
  input logic                                      wready,
  input logic [`PCIM_DATA_W+`PCIM_DATA_W/8:0]       w_bits,
  input logic                                      arvalid,
  input logic                                      arready,
  input logic [`PCIM_ID_W+`PCIM_ADDR_W+`PCIM_LEN_W-1:0] ar_bits
);

  aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(aw_bits))
    else $error("awvalid dropped or aw payload changed before awready");

  w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(w_bits))
    else $error("wvalid dropped or w payload changed before wready");

  ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(ar_bits))
    else $error("arvalid dropped or ar payload changed before arready");

  // sync reset, so valids are low from the cycle after rst_n is sampled low
  quiet_in_reset: assert property (@(posedge aclk)
    !rst_n |=> !(awvalid || wvalid || arvalid))
    else $error("valid high during reset");

endmodule

bind pcim_master pcim_props pcim_props_inst (
  .aclk    (aclk),
  .rst_n   (rst_n),
  .awvalid (awvalid),
  .awready (awready),
  .aw_bits ({awid, awaddr, awlen}),
  .wvalid  (wvalid),
  .wready  (wready),
  .w_bits  ({wdata, wstrb, wlast}),
  .arvalid (arvalid),
  .arready (arready),
  .ar_bits ({arid, araddr, arlen})
);

// ==== tb_pcim_master.sv ====
`include "pcim_consts.svh"

module tb_pcim_master;

  localparam int MAX_JOBS = 16;

  logic                      aclk;
  logic                      rst_n     = 1'b0;
  logic [`CFG_ADDR_W-1:0]    cfg_addr  = '0;
  logic [`CFG_DATA_W-1:0]    cfg_wdata = '0;
  logic                      cfg_wr    = 1'b0;
  logic                      cfg_rd    = 1'b0;
  logic                      cfg_ack;
  logic [`CFG_DATA_W-1:0]    cfg_rdata;
  logic [`PCIM_ID_W-1:0]     awid;
  logic [`PCIM_ADDR_W-1:0]   awaddr;
  logic [`PCIM_LEN_W-1:0]    awlen;
  logic                      awvalid;
  logic                      awready   = 1'b0;
  logic [`PCIM_DATA_W-1:0]   wdata;
  logic [`PCIM_DATA_W/8-1:0] wstrb;
  logic                      wlast;
  logic                      wvalid;
  logic                      wready    = 1'b0;
  logic [`PCIM_ID_W-1:0]     bid       = '0;
  logic [1:0]                bresp     = '0;
  logic                      bvalid    = 1'b0;
  logic                      bready;
  logic [`PCIM_ID_W-1:0]     arid;
  logic [`PCIM_ADDR_W-1:0]   araddr;
  logic [`PCIM_LEN_W-1:0]    arlen;
  logic                      arvalid;
  logic                      arready   = 1'b0;
  logic [`PCIM_ID_W-1:0]     rid       = '0;
  logic [`PCIM_DATA_W-1:0]   rdata     = '0;
  logic [1:0]                rresp     = '0;
  logic                      rlast     = 1'b0;
  logic                      rvalid    = 1'b0;
  logic                      rready;

  // one row per job from the stimulus file
  logic [1:0]                j_ctrl    [MAX_JOBS];
  logic [`PCIM_ADDR_W-1:0]   j_addr    [MAX_JOBS];
  logic [`PCIM_LEN_W-1:0]    j_len     [MAX_JOBS];
  logic [`PCIM_DATA_W-1:0]   j_pat     [MAX_JOBS];
  int                        j_corrupt [MAX_JOBS];
  logic [1:0]                j_bresp   [MAX_JOBS];
  logic [1:0]                j_rresp   [MAX_JOBS];
  int                        j_err     [MAX_JOBS];
  int                        j_mis     [MAX_JOBS];
  int                        j_poke    [MAX_JOBS];

  logic [`PCIM_DATA_W-1:0]   mem [logic [`PCIM_ADDR_W-1:0]];
  int                        cur         = 0;
  int                        aw_cnt      = 0;
  int                        w_cnt       = 0;
  int                        b_cnt       = 0;
  int                        ar_cnt      = 0;
  int                        r_cnt       = 0;
  logic                      b_pending   = 1'b0;
  logic                      rd_active   = 1'b0;
  logic                      b_fire      = 1'b0;
  logic                      r_fire      = 1'b0;
  logic [`PCIM_ID_W-1:0]     exp_wr_id   = '0;
  logic [`PCIM_ID_W-1:0]     exp_rd_id   = '0;
  logic [31:0]               lcg_state   = 32'hb91a;
  int                        mism_cnt    = 0;
  int                        fail_cnt    = 0;
  int                        cycle_cnt   = 0;
  int                        cycle_limit = 100000;

  pcim_master pcim_master_inst (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: jobs did not complete within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  function logic random_ready();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:30] != 2'b00;  // ready about 3 cycles in 4
  endfunction

  // unwritten words fold in both address halves
  function automatic logic [31:0] fill_word(input logic [63:0] a);
    return a[31:0] ^ a[63:32] ^ 32'hc3d2e1f0;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch %s: got %h expected %h (job %0d)", name, got, exp, cur);
    mism_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    fail_cnt++;
  endtask

  task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge aclk);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_wr    = 1'b1;
    do begin
      @(negedge aclk);
    end while (!cfg_ack);
    cfg_wr = 1'b0;
  endtask

  task automatic cfg_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge aclk);
    cfg_addr = addr;
    cfg_rd   = 1'b1;
    do begin
      @(negedge aclk);
    end while (!cfg_ack);
    data   = cfg_rdata;
    cfg_rd = 1'b0;
  endtask

  // memory model runs on the falling edge
  always @(negedge aclk) begin
    logic [63:0] beat_addr;
    if (b_fire) begin
      bvalid = 1'b0;
      b_cnt++;
      exp_wr_id++;
    end
    if (r_fire) begin
      rvalid = 1'b0;
      r_cnt++;
      if (rlast) begin
        rd_active = 1'b0;
        exp_rd_id++;
      end
    end
    if (b_pending && aw_cnt != 0 && !bvalid) begin  // after both aw and wlast
      bvalid    = 1'b1;
      bid       = exp_wr_id;
      bresp     = j_bresp[cur];
      b_pending = 1'b0;
    end
    if (rd_active && !rvalid) begin
      beat_addr = j_addr[cur] + 64'(4 * r_cnt);
      rvalid    = 1'b1;
      rid       = exp_rd_id;
      rdata     = mem.exists(beat_addr) ? mem[beat_addr] : fill_word(beat_addr);
      if (r_cnt < j_corrupt[cur]) rdata = ~rdata;
      rlast     = (r_cnt == int'(j_len[cur]));
      rresp     = rlast ? j_rresp[cur] : 2'b00;
    end
    awready = random_ready();
    wready  = random_ready();
    arready = random_ready();
    if (awvalid && awready) begin
      aw_cnt++;
      if (awid !== exp_wr_id) report_mismatch("awid", awid, exp_wr_id);
      if (awaddr !== j_addr[cur]) report_mismatch("awaddr", awaddr, j_addr[cur]);
      if (awlen !== j_len[cur]) report_mismatch("awlen", awlen, j_len[cur]);
    end
    if (wvalid && wready) begin
      beat_addr = j_addr[cur] + 64'(4 * w_cnt);
      if (wdata !== j_pat[cur] + 32'(w_cnt))
        report_mismatch("wdata", wdata, j_pat[cur] + 32'(w_cnt));
      if (wstrb !== 4'hf) report_mismatch("wstrb", wstrb, 4'hf);
      if (wlast !== (w_cnt == int'(j_len[cur])))
        report_mismatch("wlast", wlast, w_cnt == int'(j_len[cur]));
      mem[beat_addr] = wdata;
      if (wlast) b_pending = 1'b1;
      w_cnt++;
    end
    if (arvalid && arready) begin
      ar_cnt++;
      if (arid !== exp_rd_id) report_mismatch("arid", arid, exp_rd_id);
      if (araddr !== j_addr[cur]) report_mismatch("araddr", araddr, j_addr[cur]);
      if (arlen !== j_len[cur]) report_mismatch("arlen", arlen, j_len[cur]);
      rd_active = 1'b1;
    end
    b_fire = bvalid && bready;
    r_fire = rvalid && rready;
  end

  initial begin
    int          fd;
    int          njobs;
    int          maxlen;
    int          wr_beats;
    int          rd_beats;
    string       line;
    logic [31:0] rdval;
    fd = $fopen("pcim_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open pcim_stimulus.txt");
      $display("test failed");
      $finish;
    end
    njobs  = 0;
    maxlen = 0;
    while (njobs < MAX_JOBS) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;
      if ($sscanf(line, "%h %h %h %h %d %h %h %d %d %d", j_ctrl[njobs], j_addr[njobs],
                  j_len[njobs], j_pat[njobs], j_corrupt[njobs], j_bresp[njobs],
                  j_rresp[njobs], j_err[njobs], j_mis[njobs], j_poke[njobs]) == 10) begin
        if (int'(j_len[njobs]) > maxlen) maxlen = int'(j_len[njobs]);
        njobs++;
      end
    end
    $fclose(fd);
    if (njobs == 0) report_failure("no jobs found in the stimulus file");
    cycle_limit = 40 + njobs * (40 + 8 * (maxlen + 1));

    repeat (5) @(negedge aclk);
    rst_n = 1'b1;
    @(negedge aclk);
    if ({awvalid, wvalid, arvalid, cfg_ack} !== 4'b0000)
      report_failure("a valid or cfg_ack is high right after reset");
    cfg_read(`REG_STATUS, rdval);
    if (rdval !== 0) report_mismatch("status", rdval, 0);
    cfg_read(`REG_ERRS, rdval);
    if (rdval !== 0) report_mismatch("errs", rdval, 0);

    for (cur = 0; cur < njobs; cur++) begin
      aw_cnt = 0;
      w_cnt  = 0;
      b_cnt  = 0;
      ar_cnt = 0;
      r_cnt  = 0;
      cfg_write(`REG_ADDR_LO, j_addr[cur][31:0]);
      cfg_write(`REG_ADDR_HI, j_addr[cur][63:32]);
      cfg_write(`REG_LEN, 32'(j_len[cur]));
      cfg_write(`REG_PATTERN, j_pat[cur]);
      cfg_write(`REG_CTRL, 32'(j_ctrl[cur]));
      if (j_poke[cur] != 0) cfg_write(`REG_CTRL, 32'(j_ctrl[cur]));  // lands while busy
      do begin
        cfg_read(`REG_STATUS, rdval);
      end while (rdval[0]);
      if (rdval[2:1] != j_ctrl[cur]) report_mismatch("status done bits", rdval[2:1], j_ctrl[cur]);
      cfg_read(`REG_ERRS, rdval);
      if (int'(rdval[15:0]) != j_err[cur])
        report_mismatch("resp_err_cnt", rdval[15:0], j_err[cur]);
      if (int'(rdval[31:16]) != j_mis[cur])
        report_mismatch("mismatch_cnt", rdval[31:16], j_mis[cur]);
      wr_beats = j_ctrl[cur][0] ? int'(j_len[cur]) + 1 : 0;
      rd_beats = j_ctrl[cur][1] ? int'(j_len[cur]) + 1 : 0;
      if (aw_cnt != int'(j_ctrl[cur][0])) report_mismatch("aw beats", aw_cnt, j_ctrl[cur][0]);
      if (w_cnt != wr_beats) report_mismatch("w beats", w_cnt, wr_beats);
      if (b_cnt != int'(j_ctrl[cur][0])) report_mismatch("b beats", b_cnt, j_ctrl[cur][0]);
      if (ar_cnt != int'(j_ctrl[cur][1])) report_mismatch("ar beats", ar_cnt, j_ctrl[cur][1]);
      if (r_cnt != rd_beats) report_mismatch("r beats", r_cnt, rd_beats);
    end

    $display("jobs %0d, mismatches %0d, other errors %0d", njobs, mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== pcim_stimulus.txt ====
# ctrl addr len pattern corrupt bresp rresp exp_err exp_mismatch poke
# ctrl bit0 write bit1 read, first four and bresp rresp in hex, the rest decimal
3 0000000100001000 03 a5a50000 0 0 0 0 0 0
3 0000000100002000 0f fffffff8 0 0 0 0 0 1
3 0000000000004000 07 12345678 3 0 0 0 3 0
1 0000000000005000 00 deadbeef 0 2 0 1 0 0
2 0000000100001000 03 a5a50000 0 0 2 1 0 0
3 0000000200000f00 05 00000000 1 3 1 2 1 1
2 0000000200003000 01 00000000 0 0 0 0 2 0
1 ffffffff00000000 0f 0badf00d 0 0 0 0 0 0
3 0000000000006000 00 00000001 1 0 0 0 1 0

// ==== files.f ====
+incdir+.
pcim_pkg.sv
axi_if.sv
cfg_regs.sv
traffic_gen.sv
axi_chan_slice.sv
pcim_master.sv
pcim_props.sv
tb_pcim_master.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_pcim_master
FILELIST   = files.f
VFLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status follows the pass line in the simulator output
run: build
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
